// ==== midget_pkg.sv ====
// rv32e subset types; instruction fields keep five-bit register indices so decode can reject x16..x31
`default_nettype none

package midget_pkg;

   typedef logic [31:0] word_t;
   typedef logic [3:0]  reg_idx_t;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_BRANCH = 7'b1100011
   } opcode_e;

   // i-type view, also used for r-type (funct7/rs2 in imm) and u-type
   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   // branch offset is scattered, bit 0 implied zero
   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef union packed {
      i_fmt_t i_fmt;
      s_fmt_t s_fmt;
      b_fmt_t b_fmt;
   } instr_u;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND,
      ALU_PASS_B
   } alu_op_e;

   typedef enum logic {
      WB_ALU,
      WB_LOAD
   } wb_sel_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    reg_write;
      wb_sel_e wb_sel;
      logic    mem_read;
      logic    mem_write;
      logic    is_branch;
      logic    branch_ne;
      logic    illegal;
   } ctrl_t;

   localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== midget_mem_if.sv ====
// one access in flight; master raises req only when the slave is idle and holds addr/we/wdata to done
`default_nettype none
`timescale 1ns/1ps

interface midget_mem_if;
   import midget_pkg::*;

   // one-cycle request pulse from the sequencer
   logic  req;
   // write when high, else read
   logic  we;
   // byte address of the word
   word_t addr;
   word_t wdata;
   // gathered read word, valid with done
   word_t rdata;
   // one-cycle completion pulse from the bus unit
   logic  done;

   // sequencer side
   modport master (
      output req,
      output we,
      output addr,
      output wdata,
      input  rdata,
      input  done
   );

   // bus unit side
   modport slave (
      input  req,
      input  we,
      input  addr,
      input  wdata,
      output rdata,
      output done
   );

endinterface

`default_nettype wire

// ==== midget_decode.sv ====
// combinational decode of the rv32e subset only; anything else, or a register above x15, sets illegal
`default_nettype none
`timescale 1ns/1ps

module midget_decode (
   input  midget_pkg::instr_u   instr,
   output midget_pkg::ctrl_t    ctrl,
   output midget_pkg::word_t    imm,
   output midget_pkg::reg_idx_t rs1,
   output midget_pkg::reg_idx_t rs2,
   output midget_pkg::reg_idx_t rd
);
   import midget_pkg::*;

   logic uses_rs1;
   logic uses_rs2;
   logic uses_rd;
   logic is_arith;
   logic [6:0] funct7;

   // register fields sit at the same place in every format
   assign rs1    = instr.i_fmt.rs1[3:0];
   assign rs2    = instr.s_fmt.rs2[3:0];
   assign rd     = instr.i_fmt.rd[3:0];
   assign funct7 = instr.i_fmt.imm[11:5];

   always_comb begin
      ctrl        = '0;
      ctrl.alu_op = ALU_ADD;
      ctrl.wb_sel = WB_ALU;
      imm         = '0;
      uses_rs1    = 1'b0;
      uses_rs2    = 1'b0;
      uses_rd     = 1'b0;
      is_arith    = 1'b0;
      case (instr.i_fmt.opcode)
         OPC_LUI: begin
            // upper immediate goes straight through the alu
            ctrl.alu_op    = ALU_PASS_B;
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
            imm            = {instr.i_fmt.imm, instr.i_fmt.rs1, instr.i_fmt.funct3, 12'h000};
            uses_rd        = 1'b1;
         end
         OPC_OP_IMM: begin
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
            imm            = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            uses_rs1       = 1'b1;
            uses_rd        = 1'b1;
            is_arith       = 1'b1;
         end
         OPC_OP: begin
            ctrl.reg_write = 1'b1;
            uses_rs1       = 1'b1;
            uses_rs2       = 1'b1;
            uses_rd        = 1'b1;
            is_arith       = 1'b1;
            // only sub carries a nonzero funct7
            if (funct7 == 7'b0100000 && instr.i_fmt.funct3 == 3'b000) begin
               ctrl.alu_op = ALU_SUB;
               is_arith    = 1'b0;
            end else if (funct7 != 7'b0000000) begin
               ctrl.illegal = 1'b1;
            end
         end
         OPC_LOAD: begin
            // lw only, address = rs1 + imm
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.wb_sel    = WB_LOAD;
            ctrl.mem_read  = 1'b1;
            ctrl.illegal   = (instr.i_fmt.funct3 != 3'b010);
            imm            = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            uses_rs1       = 1'b1;
            uses_rd        = 1'b1;
         end
         OPC_STORE: begin
            ctrl.use_imm   = 1'b1;
            ctrl.mem_write = 1'b1;
            ctrl.illegal   = (instr.s_fmt.funct3 != 3'b010);
            imm            = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
            uses_rs1       = 1'b1;
            uses_rs2       = 1'b1;
         end
         OPC_BRANCH: begin
            // beq is funct3 000, bne is 001
            ctrl.is_branch = 1'b1;
            ctrl.branch_ne = instr.b_fmt.funct3[0];
            ctrl.illegal   = (instr.b_fmt.funct3[2:1] != 2'b00);
            imm            = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                              instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
            uses_rs1       = 1'b1;
            uses_rs2       = 1'b1;
         end
         default: ctrl.illegal = 1'b1;
      endcase
      // funct3 picks the alu op for the plain add/xor/or/and group
      if (is_arith) begin
         case (instr.i_fmt.funct3)
            3'b000:  ctrl.alu_op = ALU_ADD;
            3'b100:  ctrl.alu_op = ALU_XOR;
            3'b110:  ctrl.alu_op = ALU_OR;
            3'b111:  ctrl.alu_op = ALU_AND;
            default: ctrl.illegal = 1'b1;
         endcase
      end
      // rv32e has only x0..x15
      if ((uses_rs1 && instr.i_fmt.rs1[4]) || (uses_rs2 && instr.s_fmt.rs2[4]) ||
          (uses_rd && instr.i_fmt.rd[4])) begin
         ctrl.illegal = 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== midget_execute.sv ====
// purely combinational; result is also the effective address for lw/sw, no overflow or alignment checks
`default_nettype none
`timescale 1ns/1ps

module midget_execute (
   input  midget_pkg::ctrl_t ctrl,
   input  midget_pkg::word_t a,
   input  midget_pkg::word_t b,
   input  midget_pkg::word_t imm,
   input  midget_pkg::word_t pc,
   output midget_pkg::word_t result,
   output midget_pkg::word_t next_pc
);
   import midget_pkg::*;

   word_t op_b;
   logic  equal;
   logic  taken;

   // second operand: immediate for i/s/u forms, rs2 otherwise
   assign op_b = ctrl.use_imm ? imm : b;

   always_comb begin
      case (ctrl.alu_op)
         ALU_ADD:    result = a + op_b;
         ALU_SUB:    result = a - op_b;
         ALU_XOR:    result = a ^ op_b;
         ALU_OR:     result = a | op_b;
         ALU_AND:    result = a & op_b;
         // lui
         ALU_PASS_B: result = op_b;
         default:    result = a + op_b;
      endcase
   end

   // branch compare always uses rs2, never the immediate
   assign equal = (a == b);

   // bne inverts the sense of the compare
   assign taken = ctrl.is_branch && (equal != ctrl.branch_ne);

   // offset is relative to the branch itself
   assign next_pc = taken ? pc + imm : pc + 32'd4;

endmodule

`default_nettype wire

// ==== midget_result.sv ====
// 16 x 32 register file, x0 reads zero; write lands on the clock edge that closes the writeback cycle
`default_nettype none
`timescale 1ns/1ps

module midget_result (
   input  logic                 CLK_I,
   input  logic                 rst,
   input  midget_pkg::reg_idx_t rs1,
   input  midget_pkg::reg_idx_t rs2,
   input  midget_pkg::reg_idx_t rd,
   input  logic                 we,
   input  midget_pkg::wb_sel_e  wb_sel,
   input  midget_pkg::word_t    alu_result,
   input  midget_pkg::word_t    load_data,
   output midget_pkg::word_t    a,
   output midget_pkg::word_t    b
);
   import midget_pkg::*;

   word_t regs [16];

   // cleared on reset, then written from alu or load data
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         regs <= '{default: '0};
      end else if (we) begin
         regs[rd] <= (wb_sel == WB_LOAD) ? load_data : alu_result;
      end
   end

   // asynchronous read ports, x0 forced to zero
   assign a = (rs1 == '0) ? '0 : regs[rs1];
   assign b = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== midget_core.sv ====
// one instruction in flight, no interrupts or csrs; an illegal opcode halts the core until reset
`default_nettype none
`timescale 1ns/1ps

module midget_core (
   input  logic  CLK_I,
   input  logic  rst,
   input  logic  start,
   midget_mem_if.master mem,
   output logic  corerunning
);
   import midget_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH,
      S_EXEC,
      S_MEM,
      S_WB,
      S_HALT
   } state_e;

   state_e   state;
   word_t    pc;
   instr_u   ir;
   word_t    load_q;
   ctrl_t    ctrl;
   word_t    imm;
   reg_idx_t rs1;
   reg_idx_t rs2;
   reg_idx_t rd;
   word_t    a;
   word_t    b;
   word_t    alu_result;
   word_t    next_pc;

   midget_decode i_decode (
      .instr (ir),
      .ctrl  (ctrl),
      .imm   (imm),
      .rs1   (rs1),
      .rs2   (rs2),
      .rd    (rd)
   );

   midget_execute i_execute (
      .ctrl    (ctrl),
      .a       (a),
      .b       (b),
      .imm     (imm),
      .pc      (pc),
      .result  (alu_result),
      .next_pc (next_pc)
   );

   // register write only in wb
   midget_result i_result (
      .CLK_I      (CLK_I),
      .rst        (rst),
      .rs1        (rs1),
      .rs2        (rs2),
      .rd         (rd),
      .we         ((state == S_WB) && ctrl.reg_write),
      .wb_sel     (ctrl.wb_sel),
      .alu_result (alu_result),
      .load_data  (load_q),
      .a          (a),
      .b          (b)
   );

   // sequencer; req is a single-cycle pulse on each state entry that needs the bus
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         state   <= S_IDLE;
         pc      <= RESET_PC;
         mem.req <= 1'b0;
         mem.we  <= 1'b0;
      end else begin
         mem.req <= 1'b0;
         case (state)
            S_IDLE: begin
               if (start) begin
                  state   <= S_FETCH;
                  mem.req <= 1'b1;
                  mem.we  <= 1'b0;
               end
            end
            S_FETCH: begin
               if (mem.done) begin
                  state <= S_EXEC;
               end
            end
            S_EXEC: begin
               if (ctrl.illegal) begin
                  state <= S_HALT;
               end else if (ctrl.mem_read || ctrl.mem_write) begin
                  state   <= S_MEM;
                  mem.req <= 1'b1;
                  mem.we  <= ctrl.mem_write;
               end else begin
                  state <= S_WB;
               end
            end
            S_MEM: begin
               if (mem.done) begin
                  state <= S_WB;
               end
            end
            S_WB: begin
               // retire and fetch the next one
               pc      <= next_pc;
               state   <= S_FETCH;
               mem.req <= 1'b1;
               mem.we  <= 1'b0;
            end
            default: state <= S_HALT;
         endcase
      end
   end

   // payload, held stable between req and done
   always_ff @(posedge CLK_I) begin
      if (state == S_FETCH && mem.done) begin
         ir <= mem.rdata;
      end
      if (state == S_MEM && mem.done) begin
         load_q <= mem.rdata;
      end
      case (state)
         S_IDLE: mem.addr <= pc;
         S_EXEC: begin
            mem.addr  <= alu_result;
            mem.wdata <= b;
         end
         S_WB:    mem.addr <= next_pc;
         default: mem.addr <= mem.addr;
      endcase
   end

   // drops in the exec cycle of an illegal instruction
   assign corerunning = (state == S_FETCH) || (state == S_MEM) || (state == S_WB) ||
                        ((state == S_EXEC) && !ctrl.illegal);

endmodule

`default_nettype wire

// ==== midget_bus_unit.sv ====
// IWIDTH must be 8 or 32; narrow reads take four byte beats, writes are always one full-word beat
`default_nettype none
`timescale 1ns/1ps

module midget_bus_unit #(
   parameter int IWIDTH = 8
) (
   input  logic              CLK_I,
   input  logic              rst,
   midget_mem_if.slave       mem,
   input  logic              ACK_I,
   input  logic [IWIDTH-1:0] DAT_I,
   output logic              CYC_O,
   output logic              STB_O,
   output logic              WE_O,
   output logic [3:0]        SEL_O,
   output midget_pkg::word_t ADR_O,
   output midget_pkg::word_t DAT_O
);
   import midget_pkg::*;

   localparam int         NBEATS    = 32 / IWIDTH;
   localparam logic [1:0] LAST_BEAT = 2'(NBEATS - 1);

   logic       cyc;
   logic [1:0] beat;
   logic       last;
   word_t      gather;

   // writes never split
   assign last = mem.we || (beat == LAST_BEAT);

   always_ff @(posedge CLK_I) begin
      if (rst) begin
         cyc      <= 1'b0;
         beat     <= '0;
         mem.done <= 1'b0;
      end else begin
         mem.done <= 1'b0;
         if (!cyc) begin
            if (mem.req) begin
               cyc  <= 1'b1;
               beat <= '0;
            end
         end else if (ACK_I) begin
            // done comes one cycle after the final ack
            if (last) begin
               cyc      <= 1'b0;
               mem.done <= 1'b1;
            end else begin
               beat <= beat + 2'd1;
            end
         end
      end
   end

   // little-endian placement, lane 0 first
   always_ff @(posedge CLK_I) begin
      if (cyc && ACK_I && !mem.we) begin
         gather[beat*IWIDTH +: IWIDTH] <= DAT_I;
      end
   end

   assign mem.rdata = gather;

   // strobe held through wait states
   assign CYC_O = cyc;
   assign STB_O = cyc;
   assign WE_O  = cyc && mem.we;
   assign ADR_O = mem.addr + word_t'(beat);
   assign DAT_O = mem.wdata;
   // one-hot byte lane per narrow beat
   assign SEL_O = (mem.we || NBEATS == 1) ? 4'b1111 : 4'(4'b0001 << beat);

endmodule

`default_nettype wire

// ==== midget_top.sv ====
// DAT_I width IWIDTH is 8 or 32 only; start is sampled while idle, no interrupt input
`default_nettype none
`timescale 1ns/1ps

module midget_top #(
   parameter int IWIDTH = 8
) (
   input  logic              CLK_I,
   input  logic              rst,
   input  logic              start,
   input  logic              ACK_I,
   input  logic [IWIDTH-1:0] DAT_I,
   output logic              CYC_O,
   output logic              STB_O,
   output logic              WE_O,
   output logic [3:0]        SEL_O,
   output midget_pkg::word_t ADR_O,
   output midget_pkg::word_t DAT_O,
   output logic              corerunning
);

   // sequencer to bus unit
   midget_mem_if mem_if ();

   midget_core i_core (
      .CLK_I       (CLK_I),
      .rst         (rst),
      .start       (start),
      .mem         (mem_if.master),
      .corerunning (corerunning)
   );

   // wishbone master, read width set here
   midget_bus_unit #(
      .IWIDTH (IWIDTH)
   ) i_bus_unit (
      .CLK_I (CLK_I),
      .rst   (rst),
      .mem   (mem_if.slave),
      .ACK_I (ACK_I),
      .DAT_I (DAT_I),
      .CYC_O (CYC_O),
      .STB_O (STB_O),
      .WE_O  (WE_O),
      .SEL_O (SEL_O),
      .ADR_O (ADR_O),
      .DAT_O (DAT_O)
   );

endmodule

`default_nettype wire

// ==== midget_tb_clock.sv ====
// 4 ns clock from time zero; rst is high for 8 cycles at start and again after each restart pulse
`default_nettype none
`timescale 1ns/1ps

module midget_tb_clock (
   input  logic restart,
   output logic CLK_I,
   output logic rst
);

   // reset length in cycles, counts down to zero
   logic [3:0] rst_cnt = 4'd8;

   initial begin
      CLK_I = 1'b0;
      forever #2 CLK_I = ~CLK_I;
   end

   // synchronous restart of the reset window
   always @(posedge CLK_I) begin
      if (restart) begin
         rst_cnt <= 4'd8;
      end else if (rst_cnt != 4'd0) begin
         rst_cnt <= rst_cnt - 4'd1;
      end
   end

   assign rst = (rst_cnt != 4'd0);

endmodule

`default_nettype wire

// ==== midget_tb_properties.sv ====
// wishbone master checks for midget_top only; checks are idle while rst is high except the reset rule
`default_nettype none
`timescale 1ns/1ps

module midget_tb_properties (
   input logic       CLK_I,
   input logic       rst,
   input logic       CYC_O,
   input logic       STB_O,
   input logic       ACK_I,
   input logic [3:0] SEL_O
);

   // strobe only inside a cycle
   a_stb_in_cyc: assert property (@(posedge CLK_I) disable iff (rst) STB_O |-> CYC_O)
      else $error("STB_O high without CYC_O");

   // byte lanes frozen during wait states
   a_sel_stable: assert property (@(posedge CLK_I) disable iff (rst)
      (STB_O && !ACK_I) |=> $stable(SEL_O))
      else $error("SEL_O changed while STB_O waited for ACK_I");

   // no bus cycle once reset has been seen
   a_no_cyc_in_rst: assert property (@(posedge CLK_I) rst |=> !CYC_O)
      else $error("CYC_O high during reset");

endmodule

bind midget_top midget_tb_properties i_properties (
   .CLK_I (CLK_I),
   .rst   (rst),
   .CYC_O (CYC_O),
   .STB_O (STB_O),
   .ACK_I (ACK_I),
   .SEL_O (SEL_O)
);

`default_nettype wire

// ==== midget_tb.sv ====
// runs midget_top with an 8-bit DAT_I against a 4 KB word memory; every program ends on an illegal opcode
`default_nettype none
`timescale 1ns/1ps

module midget_tb;
   import midget_pkg::*;

   // instructions per test, used for the watchdog budget
   localparam int TOTAL_INSTR     = 3 + 21 + 8 + 12 + 21 + 4;
   localparam int IDLE_CYCLES     = 10 + 100 + 6 * 12;
   localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 40 + IDLE_CYCLES;
   localparam int MEM_WORDS       = 1024;
   localparam word_t ILLEGAL_WORD = 32'h0000_0000;
   localparam word_t ARITH_BASE   = 32'h0000_0100;
   localparam logic [31:0] SEED   = 32'hb802_4f57;

   logic       restart = 1'b0;
   logic       CLK_I;
   logic       rst;
   logic       start = 1'b0;
   logic       ACK_I = 1'b0;
   logic [7:0] DAT_I = 8'h00;
   logic       CYC_O;
   logic       STB_O;
   logic       WE_O;
   logic [3:0] SEL_O;
   word_t      ADR_O;
   word_t      DAT_O;
   logic       corerunning;

   // memory model and its bookkeeping
   word_t       mem [MEM_WORDS];
   logic        armed = 1'b0;
   logic        seeded = 1'b0;
   int unsigned waits = 0;
   bit          max_wait = 1'b0;
   word_t       rd_addr [$];
   logic [3:0]  rd_sel [$];
   word_t       wr_addr [$];
   word_t       wr_data [$];
   logic [3:0]  wr_sel [$];
   int          prog_len;

   int    tests_run = 0;
   int    checks = 0;
   int    errors = 0;
   int    test_errors = 0;
   string cur_name;

   midget_tb_clock i_clock (
      .restart (restart),
      .CLK_I   (CLK_I),
      .rst     (rst)
   );

   midget_top #(
      .IWIDTH (8)
   ) i_midget_top (
      .CLK_I       (CLK_I),
      .rst         (rst),
      .start       (start),
      .ACK_I       (ACK_I),
      .DAT_I       (DAT_I),
      .CYC_O       (CYC_O),
      .STB_O       (STB_O),
      .WE_O        (WE_O),
      .SEL_O       (SEL_O),
      .ADR_O       (ADR_O),
      .DAT_O       (DAT_O),
      .corerunning (corerunning)
   );

   // byte lane picked by the one-hot select
   function automatic logic [7:0] lane_byte(input word_t w, input logic [3:0] sel);
      case (sel)
         4'b0001: return w[7:0];
         4'b0010: return w[15:8];
         4'b0100: return w[23:16];
         4'b1000: return w[31:24];
         default: return 8'h00;
      endcase
   endfunction

   // slave arms a random wait per beat and then acks for one cycle
   always @(posedge CLK_I) begin
      if (rst) begin
         ACK_I <= 1'b0;
         armed <= 1'b0;
         if (!seeded) begin
            // one seed for the whole run
            void'($urandom(SEED));
            seeded <= 1'b1;
         end
      end else if (ACK_I) begin
         ACK_I <= 1'b0;
         armed <= 1'b0;
      end else if (STB_O) begin
         if (!armed) begin
            armed <= 1'b1;
            waits <= max_wait ? 3 : $urandom_range(3, 0);
         end else if (waits != 0) begin
            waits <= waits - 1;
         end else begin
            ACK_I <= 1'b1;
            if (WE_O) begin
               mem[ADR_O[11:2]] <= DAT_O;
               wr_addr.push_back(ADR_O);
               wr_data.push_back(DAT_O);
               wr_sel.push_back(SEL_O);
            end else begin
               DAT_I <= lane_byte(mem[ADR_O[11:2]], SEL_O);
               rd_addr.push_back(ADR_O);
               rd_sel.push_back(SEL_O);
            end
         end
      end
   end

   // instruction encoders in the RV32 field layout
   function automatic word_t enc_i(input opcode_e opc, input int rd, input logic [2:0] f3,
                                   input int rs1, input logic [11:0] imm);
      return {imm, 5'(rs1), f3, 5'(rd), opc};
   endfunction

   function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3, input int rd,
                                   input int rs1, input int rs2);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
   endfunction

   // sw only
   function automatic word_t enc_s(input int rs2, input int rs1, input logic [11:0] imm);
      return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], OPC_STORE};
   endfunction

   // offset in bytes with bit 0 dropped
   function automatic word_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                   input logic [12:0] off);
      return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], OPC_BRANCH};
   endfunction

   function automatic word_t enc_u(input int rd, input logic [19:0] imm);
      return {imm, 5'(rd), OPC_LUI};
   endfunction

   task automatic emit(input word_t w);
      mem[prog_len] = w;
      prog_len++;
   endtask

   task automatic check_word(input string what, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         test_errors++;
         $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
   endtask

   task automatic check_sel(input string what, input logic [3:0] got, input logic [3:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         test_errors++;
         $display("** Error at %0t ns: %s = %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         test_errors++;
         $display("** Error at %0t ns: %s = %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         test_errors++;
         $display("** Error at %0t ns: %s = %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // re-reset the DUT, refill memory, clear the logs
   task automatic begin_test(input string name);
      cur_name    = name;
      test_errors = 0;
      max_wait    = 1'b0;
      prog_len    = 0;
      @(posedge CLK_I);
      restart <= 1'b1;
      @(posedge CLK_I);
      restart <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         // fill differs at every address
         mem[i] = ~(word_t'(i) << 2) ^ 32'h5a5a_0000;
      end
      rd_addr.delete();
      rd_sel.delete();
      wr_addr.delete();
      wr_data.delete();
      wr_sel.delete();
      do @(negedge CLK_I); while (rst);
   endtask

   task automatic end_test;
      tests_run++;
      if (test_errors == 0) begin
         $display("%-14s ok", cur_name);
      end else begin
         $display("%-14s FAILED with %0d mismatches", cur_name, test_errors);
      end
   endtask

   // start pulse and wait for the core to stop
   task automatic run_program;
      @(posedge CLK_I);
      start <= 1'b1;
      @(posedge CLK_I);
      start <= 1'b0;
      @(negedge CLK_I);
      check_flag("corerunning after start", corerunning, 1'b1);
      while (corerunning) begin
         @(negedge CLK_I);
      end
   endtask

   task automatic test_reset_start;
      begin_test("reset_start");
      emit(enc_i(OPC_OP_IMM, 1, 3'b000, 0, 12'd1));
      emit(enc_i(OPC_OP_IMM, 2, 3'b000, 0, 12'd2));
      emit(ILLEGAL_WORD);
      // quiet bus until start
      repeat (10) begin
         @(negedge CLK_I);
         check_flag("CYC_O", CYC_O, 1'b0);
         check_flag("corerunning", corerunning, 1'b0);
      end
      run_program();
      // three fetches of four byte beats each
      check_count("read beats", rd_addr.size(), 12);
      for (int i = 0; i < rd_addr.size() && i < 12; i++) begin
         check_word("ADR_O", rd_addr[i], RESET_PC + word_t'(4 * (i / 4) + i % 4));
         check_sel("SEL_O", rd_sel[i], 4'(1 << (i % 4)));
      end
      end_test();
   endtask

   // LUI, immediate and register ops, then SW of x1..x10
   task automatic build_arith;
      emit(enc_u(1, 20'h12345));
      emit(enc_i(OPC_OP_IMM, 2, 3'b000, 1, 12'h678));
      emit(enc_i(OPC_OP_IMM, 3, 3'b100, 2, 12'hfff));
      emit(enc_i(OPC_OP_IMM, 4, 3'b110, 0, 12'h0f0));
      emit(enc_i(OPC_OP_IMM, 5, 3'b111, 2, 12'h0ff));
      emit(enc_r(7'h00, 3'b000, 6, 2, 4));
      emit(enc_r(7'h20, 3'b000, 7, 4, 2));
      emit(enc_r(7'h00, 3'b100, 8, 2, 3));
      emit(enc_r(7'h00, 3'b110, 9, 4, 5));
      emit(enc_r(7'h00, 3'b111, 10, 2, 3));
      for (int r = 1; r <= 10; r++) begin
         emit(enc_s(r, 0, 12'(ARITH_BASE + 4 * (r - 1))));
      end
      emit(ILLEGAL_WORD);
   endtask

   // expected register values from the RV32 rules
   task automatic check_arith;
      word_t x [11];
      x[1]  = 32'h1234_5000;
      x[2]  = x[1] + 32'h0000_0678;
      // xori with -1 sign-extends to all ones
      x[3]  = x[2] ^ 32'hffff_ffff;
      x[4]  = 32'h0000_0000 | 32'h0000_00f0;
      x[5]  = x[2] & 32'h0000_00ff;
      x[6]  = x[2] + x[4];
      x[7]  = x[4] - x[2];
      x[8]  = x[2] ^ x[3];
      x[9]  = x[4] | x[5];
      x[10] = x[2] & x[3];
      check_count("writes", wr_addr.size(), 10);
      for (int i = 0; i < wr_addr.size() && i < 10; i++) begin
         check_word("ADR_O", wr_addr[i], ARITH_BASE + word_t'(4 * i));
         check_word("DAT_O", wr_data[i], x[i + 1]);
         check_sel("SEL_O", wr_sel[i], 4'b1111);
      end
   endtask

   task automatic test_arith;
      begin_test("arith");
      build_arith();
      run_program();
      check_arith();
      end_test();
   endtask

   task automatic test_load;
      begin_test("load");
      mem[32'h300 >> 2] = 32'h8877_6655;
      emit(enc_u(1, 20'ha1b2c));
      emit(enc_i(OPC_OP_IMM, 1, 3'b000, 1, 12'h3d4));
      emit(enc_s(1, 0, 12'h200));
      emit(enc_i(OPC_LOAD, 2, 3'b010, 0, 12'h200));
      emit(enc_s(2, 0, 12'h204));
      emit(enc_i(OPC_LOAD, 3, 3'b010, 0, 12'h300));
      emit(enc_s(3, 0, 12'h208));
      emit(ILLEGAL_WORD);
      run_program();
      check_count("writes", wr_addr.size(), 3);
      if (wr_addr.size() == 3) begin
         check_word("ADR_O", wr_addr[0], 32'h0000_0200);
         check_word("DAT_O", wr_data[0], 32'ha1b2_c3d4);
         // round trip through four byte beats
         check_word("ADR_O", wr_addr[1], 32'h0000_0204);
         check_word("DAT_O", wr_data[1], 32'ha1b2_c3d4);
         check_word("ADR_O", wr_addr[2], 32'h0000_0208);
         check_word("DAT_O", wr_data[2], 32'h8877_6655);
      end
      end_test();
   endtask

   task automatic test_branch;
      word_t fetches [$];
      word_t exp_fetch [10];
      begin_test("branch");
      exp_fetch = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd20, 32'd24, 32'd28, 32'd36, 32'd40, 32'd44};
      emit(enc_i(OPC_OP_IMM, 1, 3'b000, 0, 12'd5));
      emit(enc_i(OPC_OP_IMM, 2, 3'b000, 0, 12'd5));
      emit(enc_i(OPC_OP_IMM, 3, 3'b000, 0, 12'd7));
      // beq taken over a store
      emit(enc_b(3'b000, 1, 2, 13'd8));
      emit(enc_s(1, 0, 12'h300));
      // beq not taken
      emit(enc_b(3'b000, 1, 3, 13'd8));
      emit(enc_s(1, 0, 12'h304));
      // bne taken
      emit(enc_b(3'b001, 1, 3, 13'd8));
      emit(enc_s(1, 0, 12'h308));
      // bne not taken
      emit(enc_b(3'b001, 1, 2, 13'd8));
      emit(enc_s(3, 0, 12'h30c));
      emit(ILLEGAL_WORD);
      run_program();
      // first byte beat marks an instruction fetch
      for (int i = 0; i < rd_addr.size(); i++) begin
         if (rd_sel[i] == 4'b0001) begin
            fetches.push_back(rd_addr[i]);
         end
      end
      check_count("fetches", fetches.size(), 10);
      for (int i = 0; i < fetches.size() && i < 10; i++) begin
         check_word("fetch ADR_O", fetches[i], exp_fetch[i]);
      end
      check_count("writes", wr_addr.size(), 2);
      if (wr_addr.size() == 2) begin
         check_word("ADR_O", wr_addr[0], 32'h0000_0304);
         check_word("DAT_O", wr_data[0], 32'd5);
         check_word("ADR_O", wr_addr[1], 32'h0000_030c);
         check_word("DAT_O", wr_data[1], 32'd7);
      end
      end_test();
   endtask

   // same program with three wait cycles on every beat
   task automatic test_backpressure;
      begin_test("backpressure");
      max_wait = 1'b1;
      build_arith();
      run_program();
      check_arith();
      end_test();
   endtask

   task automatic test_illegal;
      logic cyc_seen;
      begin_test("illegal");
      cyc_seen = 1'b0;
      emit(enc_i(OPC_OP_IMM, 1, 3'b000, 0, 12'h05a));
      emit(enc_s(1, 0, 12'h100));
      // jal is outside the subset
      emit(32'h0000_006f);
      emit(enc_i(OPC_OP_IMM, 2, 3'b000, 0, 12'd1));
      run_program();
      repeat (100) begin
         @(negedge CLK_I);
         if (CYC_O) begin
            cyc_seen = 1'b1;
         end
      end
      check_flag("CYC_O after halt", cyc_seen, 1'b0);
      // halted core stays down without a reset
      check_flag("corerunning after halt", corerunning, 1'b0);
      check_count("read beats", rd_addr.size(), 12);
      check_count("writes", wr_addr.size(), 1);
      if (wr_addr.size() == 1) begin
         check_word("DAT_O", wr_data[0], 32'h0000_005a);
      end
      end_test();
   endtask

   initial begin
      test_reset_start();
      test_arith();
      test_load();
      test_branch();
      test_backpressure();
      test_illegal();
      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // budget of 40 cycles per instruction plus idle and reset time
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge CLK_I);
      $display("watchdog expired after %0d cycles, the core did not stop", WATCHDOG_CYCLES);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== midget_top.f ====
midget_pkg.sv
midget_mem_if.sv
midget_decode.sv
midget_execute.sv
midget_result.sv
midget_core.sv
midget_bus_unit.sv
midget_top.sv
midget_tb_clock.sv
midget_tb_properties.sv
midget_tb.sv
